/* Makefile */
# Verilator lint and simulation of the sram subsystem testbench
# override any variable on the command line, e.g. make sim SEED=7 LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_sram_subsys
SEED      ?= 1
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FLIST     ?= vlog.f

SRCS   := $(filter-out +incdir+%,$(shell cat $(FLIST)))
VFLAGS := --timing -f $(FLIST) --top-module $(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS)

$(OBJ_DIR)/V$(TOP): $(SRCS) sram_settings.svh $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -Mdir $(OBJ_DIR)

# the run result is taken from the log, not from the exit status
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) +verilator+seed+$(SEED) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* sram8_inferred.sv */
//////////////////////////////
// one 8-bit memory lane, synchronous write and registered read
// instantiated once per byte lane by srambytes_tech
//////////////////////////////
`timescale 1ns/1ps

module sram8_inferred #(
   parameter integer abits = $bits(sram_pkg::sram_row_type)  // row address bits
) (
   input  logic                    clk,
   input  sram_pkg::sram_row_type  address,
   input  logic                    we,
   input  sram_pkg::sram_byte_type wdata,
   output sram_pkg::sram_byte_type rdata
);

   sram_pkg::sram_byte_type mem [0:2**abits-1];
   logic [abits-1:0]        row;

   assign row = address[abits-1:0];

   // a write cycle leaves rdata holding the last read
   always_ff @(posedge clk) begin
      if (we) begin
         mem[row] <= wdata;
      end else begin
         rdata <= mem[row];
      end
   end

endmodule

/* sram_pkg.sv */
//////////////////////////////
// memory side types for the byte lanes and the request front end
//////////////////////////////

`include "sram_settings.svh"

package sram_pkg;

   // contents of one byte lane
   typedef logic [7:0] sram_byte_type;

   // row address inside a lane, the byte offset bits dropped
   typedef logic [`SRAM_ABITS-`SYSBUS_ADDR_OFFSET-1:0] sram_row_type;

   // front end states
   typedef enum logic {
      ST_CLEAR,   // zero-fill after reset
      ST_RUN      // normal requests
   } req_state_type;

endpackage

/* sram_req_ctrl.sv */
//////////////////////////////
// request front end, zero-fills the memory after reset then serves requests
// all memory and tag outputs are registered at the edge that samples req_valid
//////////////////////////////
`timescale 1ns/1ps

`include "sram_settings.svh"

module sram_req_ctrl (
   input  logic                                  clk,
   input  logic                                  rst_n,
   input  logic                                  req_valid,
   input  logic                                  req_write,
   input  types_amba_pkg::global_addr_type       req_addr,
   input  types_amba_pkg::sysbus_strb_type       req_wstrb,
   input  types_amba_pkg::sysbus_data_type       req_wdata,
   output logic                                  ready,
   output types_amba_pkg::global_addr_array_type raddr,
   output types_amba_pkg::global_addr_array_type waddr,
   output logic                                  we,
   output types_amba_pkg::sysbus_strb_type       wstrb,
   output types_amba_pkg::sysbus_data_type       wdata,
   output logic                                  tag_valid,
   output logic                                  tag_write,
   output logic                                  tag_err
);

   sram_pkg::req_state_type         state;
   sram_pkg::sram_row_type          row_cnt;   // clear pointer
   logic                            out_of_range;
   types_amba_pkg::global_addr_type req_base;  // request address, word aligned
   types_amba_pkg::global_addr_type clr_base;

   assign out_of_range = |req_addr[`SYSBUS_ADDR_BITS-1:`SRAM_ABITS];
   assign req_base = {req_addr[`SYSBUS_ADDR_BITS-1:`SYSBUS_ADDR_OFFSET],
                      {`SYSBUS_ADDR_OFFSET{1'b0}}};
   assign clr_base = types_amba_pkg::global_addr_type'({row_cnt, {`SYSBUS_ADDR_OFFSET{1'b0}}});
   assign ready = (state == sram_pkg::ST_RUN);

   //////////////////////////////
   // control
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state     <= sram_pkg::ST_CLEAR;
         row_cnt   <= '0;
         we        <= 1'b0;
         tag_valid <= 1'b0;
      end else begin
         tag_valid <= req_valid;  // every request gets a tag
         case (state)
            sram_pkg::ST_CLEAR: begin
               we      <= 1'b1;
               row_cnt <= row_cnt + 1'b1;
               if (row_cnt == '1) state <= sram_pkg::ST_RUN;  // last row written
            end
            default: we <= req_valid & req_write & ~out_of_range;
         endcase
      end
   end

   //////////////////////////////
   // payload
   //////////////////////////////

   always_ff @(posedge clk) begin
      tag_write <= req_write;
      tag_err   <= out_of_range | (state != sram_pkg::ST_RUN);
      if (state == sram_pkg::ST_CLEAR) begin
         wstrb <= '1;
         wdata <= '0;
         for (int k = 0; k < $size(waddr); k++) waddr[k] <= clr_base + 32'(k * `SYSBUS_ALIGN_BYTES);
      end else if (req_valid && !out_of_range) begin
         for (int k = 0; k < $size(raddr); k++) raddr[k] <= req_base + 32'(k * `SYSBUS_ALIGN_BYTES);
         if (req_write) begin
            wstrb <= req_wstrb;
            wdata <= req_wdata;
            for (int k = 0; k < $size(waddr); k++) waddr[k] <= req_base + 32'(k * `SYSBUS_ALIGN_BYTES);
         end
      end
   end

endmodule

/* sram_resp_ctrl.sv */
//////////////////////////////
// response stage, one resp_valid strobe per tag from the front end
// tags wait one cycle for the memory read, then the response is registered
//////////////////////////////
`timescale 1ns/1ps

module sram_resp_ctrl (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            tag_valid,
   input  logic                            tag_write,
   input  logic                            tag_err,
   input  types_amba_pkg::sysbus_data_type rdata,
   output logic                            resp_valid,
   output types_amba_pkg::sysbus_data_type resp_rdata,
   output logic                            resp_err
);

   logic tag_valid_d;
   logic tag_write_d;
   logic tag_err_d;
   logic good_read;  // memory data goes out only here

   assign good_read = tag_valid_d & ~tag_write_d & ~tag_err_d;

   //////////////////////////////
   // tag delay, matches memory latency
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         tag_valid_d <= 1'b0;
      end else begin
         tag_valid_d <= tag_valid;
      end
      tag_write_d <= tag_write;
      tag_err_d   <= tag_err;
   end

   //////////////////////////////
   // response register
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         resp_valid <= 1'b0;
         resp_err   <= 1'b0;
      end else begin
         resp_valid <= tag_valid_d;
         resp_err   <= tag_valid_d & tag_err_d;
      end
      resp_rdata <= good_read ? rdata : '0;  // writes and errors return zero
   end

endmodule

/* sram_settings.svh */
//////////////////////////////
// bus widths and memory size for the sram subsystem
// include in any file that sizes a port or a type from these values
//////////////////////////////
`ifndef SRAM_SETTINGS_SVH
`define SRAM_SETTINGS_SVH

// system bus
`define SYSBUS_DATA_BITS   64
`define SYSBUS_DATA_BYTES  8
`define SYSBUS_ADDR_BITS   32

// one address array entry covers this many bytes of the bus word
`define SYSBUS_ALIGN_BYTES 4

// byte select bits within one bus word
`define SYSBUS_ADDR_OFFSET 3

// memory byte address width, 1024 bytes
`define SRAM_ABITS         10

`endif

/* sram_subsys_top.sv */
//////////////////////////////
// memory subsystem top, front end to memory to response stage
// responses follow requests by three cycles, in order
//////////////////////////////
`timescale 1ns/1ps

`include "sram_settings.svh"

module sram_subsys_top (
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            req_valid,
   input  logic                            req_write,
   input  types_amba_pkg::global_addr_type req_addr,
   input  types_amba_pkg::sysbus_strb_type req_wstrb,
   input  types_amba_pkg::sysbus_data_type req_wdata,
   output logic                            ready,
   output logic                            resp_valid,
   output types_amba_pkg::sysbus_data_type resp_rdata,
   output logic                            resp_err
);

   types_amba_pkg::global_addr_array_type raddr;
   types_amba_pkg::global_addr_array_type waddr;
   logic                                  we;
   types_amba_pkg::sysbus_strb_type       wstrb;
   types_amba_pkg::sysbus_data_type       wdata;
   types_amba_pkg::sysbus_data_type       rdata;
   logic                                  tag_valid;
   logic                                  tag_write;
   logic                                  tag_err;

   sram_req_ctrl u_req (
      .clk        (clk),        .rst_n      (rst_n),
      .req_valid  (req_valid),  .req_write  (req_write),
      .req_addr   (req_addr),   .req_wstrb  (req_wstrb),
      .req_wdata  (req_wdata),  .ready      (ready),
      .raddr      (raddr),      .waddr      (waddr),
      .we         (we),         .wstrb      (wstrb),
      .wdata      (wdata),      .tag_valid  (tag_valid),
      .tag_write  (tag_write),  .tag_err    (tag_err)
   );

   srambytes_tech #(.abits(`SRAM_ABITS)) u_mem (
      .clk   (clk),   .raddr (raddr), .waddr (waddr), .we (we),
      .wstrb (wstrb), .wdata (wdata), .rdata (rdata)
   );

   sram_resp_ctrl u_resp (
      .clk        (clk),        .rst_n      (rst_n),
      .tag_valid  (tag_valid),  .tag_write  (tag_write),
      .tag_err    (tag_err),    .rdata      (rdata),
      .resp_valid (resp_valid), .resp_rdata (resp_rdata),
      .resp_err   (resp_err)
   );

endmodule

/* srambytes_tech.sv */
//////////////////////////////
// byte-strobed memory built from eight 8-bit lanes
// one cycle from address to rdata, write wins over read in a cycle
//////////////////////////////
`timescale 1ns/1ps

`include "sram_settings.svh"

module srambytes_tech #(
   parameter integer abits = `SRAM_ABITS  // byte address width
) (
   input  logic                                  clk,
   input  types_amba_pkg::global_addr_array_type raddr,
   input  types_amba_pkg::global_addr_array_type waddr,
   input  logic                                  we,
   input  types_amba_pkg::sysbus_strb_type       wstrb,
   input  types_amba_pkg::sysbus_data_type       wdata,
   output types_amba_pkg::sysbus_data_type       rdata
);

   localparam integer dw = `SYSBUS_ADDR_OFFSET;

   logic [`SYSBUS_DATA_BYTES-1:0] wr_ena;
   sram_pkg::sram_row_type        address [0:`SYSBUS_DATA_BYTES-1];

   //////////////////////////////
   // byte lanes
   //////////////////////////////

   for (genvar n = 0; n < `SYSBUS_DATA_BYTES; n++) begin : rx

      assign wr_ena[n] = we & wstrb[n];

      // lanes 0..3 follow entry 0, lanes 4..7 entry 1
      assign address[n] = we ?
         sram_pkg::sram_row_type'(waddr[n / `SYSBUS_ALIGN_BYTES][abits-1:dw]) :
         sram_pkg::sram_row_type'(raddr[n / `SYSBUS_ALIGN_BYTES][abits-1:dw]);

      sram8_inferred #(
         .abits   (abits - dw)
      ) x0 (
         .clk     (clk),
         .address (address[n]),
         .we      (wr_ena[n]),
         .wdata   (wdata[8*n +: 8]),
         .rdata   (rdata[8*n +: 8])
      );

   end : rx

endmodule

/* tb_sram_subsys.sv */
//////////////////////////////
// testbench for the sram subsystem, compiled through vlog.f
// drives bus requests and checks each response against a byte array model
//////////////////////////////
`timescale 1ns/1ps

`include "sram_settings.svh"

module tb_sram_subsys;

   localparam int MEM_BYTES   = 2**`SRAM_ABITS;
   localparam int ROWS        = MEM_BYTES / `SYSBUS_DATA_BYTES;
   localparam int CLEAR_EDGES = ROWS;  // sampled edges from reset release to ready
   localparam int RESP_LAT    = 3;     // sampling edge to the edge that sees resp_valid
   localparam int TIMEOUT     = 400;
   localparam int N_RANDOM    = 2000;

   logic                            clk;
   logic                            rst_n;
   logic                            req_valid;
   logic                            req_write;
   types_amba_pkg::global_addr_type req_addr;
   types_amba_pkg::sysbus_strb_type req_wstrb;
   types_amba_pkg::sysbus_data_type req_wdata;
   logic                            ready;
   logic                            resp_valid;
   types_amba_pkg::sysbus_data_type resp_rdata;
   logic                            resp_err;

   sram_pkg::sram_byte_type         model [0:MEM_BYTES-1];
   types_amba_pkg::sysbus_data_type exp_data_q [$];
   logic                            exp_err_q [$];
   int unsigned                     exp_cyc_q [$];
   int unsigned                     cyc = 0;
   int unsigned                     run_edges = 0;  // edges sampled out of reset

   sram_subsys_top dut0 (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req_write  (req_write),
      .req_addr   (req_addr),
      .req_wstrb  (req_wstrb),
      .req_wdata  (req_wdata),
      .ready      (ready),
      .resp_valid (resp_valid),
      .resp_rdata (resp_rdata),
      .resp_err   (resp_err)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   //////////////////////////////
   // checks and model
   //////////////////////////////

   task automatic report_failure(input string what);
      $display("%s", what);
      $display("ERRORS FOUND");
      $fatal(1, "simulation stopped at the first failure");
   endtask

   task automatic check_data(input string name, input types_amba_pkg::sysbus_data_type got,
                             input types_amba_pkg::sysbus_data_type exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED at %0t: %s got %h expected %h",
                                  $time, name, got, exp));
      end
   endtask

   task automatic check_err(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         report_failure($sformatf("CHECK FAILED at %0t: %s got %b expected %b",
                                  $time, name, got, exp));
      end
   endtask

   // one request against the byte model, queues the response it must produce
   function automatic void ref_access(input logic is_ready, input logic write,
                                      input types_amba_pkg::global_addr_type addr,
                                      input types_amba_pkg::sysbus_strb_type strb,
                                      input types_amba_pkg::sysbus_data_type wdata,
                                      input int unsigned at_cyc);
      types_amba_pkg::sysbus_data_type rd;
      logic                            err;
      int                              base;
      rd   = '0;
      err  = !is_ready || (addr >= MEM_BYTES);
      base = int'(addr[`SRAM_ABITS-1:0]);
      base = base - (base % `SYSBUS_DATA_BYTES);  // low address bits ignored
      if (!err) begin
         for (int b = 0; b < `SYSBUS_DATA_BYTES; b++) begin
            if (write && strb[b]) model[base+b] = wdata[8*b +: 8];
            if (!write) rd[8*b +: 8] = model[base+b];
         end
      end
      exp_data_q.push_back(rd);
      exp_err_q.push_back(err);
      exp_cyc_q.push_back(at_cyc + RESP_LAT);
   endfunction

   // request monitor, sees the values the DUT samples at this edge
   always @(posedge clk) begin
      if (rst_n !== 1'b1) begin
         run_edges <= 0;
      end else begin
         check_err("ready", ready, run_edges >= CLEAR_EDGES);
         if (req_valid === 1'b1) begin
            ref_access(run_edges >= CLEAR_EDGES, req_write, req_addr, req_wstrb,
                       req_wdata, cyc);
         end
         run_edges <= run_edges + 1;
      end
   end

   // compare process
   always @(posedge clk) begin
      if (resp_valid === 1'b1) begin
         if (exp_data_q.size() == 0) begin
            report_failure("a response strobe came with no request outstanding");
         end else begin
            if (cyc != exp_cyc_q[0]) begin
               report_failure($sformatf("response came at cycle %0d, expected at cycle %0d",
                                        cyc, exp_cyc_q[0]));
            end
            check_err("resp_err", resp_err, exp_err_q.pop_front());
            check_data("resp_rdata", resp_rdata, exp_data_q.pop_front());
            void'(exp_cyc_q.pop_front());
         end
      end
   end

   //////////////////////////////
   // stimulus
   //////////////////////////////

   task automatic issue(input logic write, input types_amba_pkg::global_addr_type addr,
                        input types_amba_pkg::sysbus_strb_type strb,
                        input types_amba_pkg::sysbus_data_type data);
      @(posedge clk);
      req_valid <= 1'b1;
      req_write <= write;
      req_addr  <= addr;
      req_wstrb <= strb;
      req_wdata <= data;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         req_valid <= 1'b0;
      end
   endtask

   function automatic types_amba_pkg::sysbus_data_type rand_data();
      return {$urandom, $urandom};
   endfunction

   // mostly in range, now and then with high address bits set
   function automatic types_amba_pkg::global_addr_type rand_addr(input logic allow_high);
      types_amba_pkg::global_addr_type a;
      a = $urandom % MEM_BYTES;
      if (allow_high && ($urandom % 8 == 0)) a = a | ($urandom << `SRAM_ABITS);
      return a;
   endfunction

   initial begin
      int                              n;
      types_amba_pkg::global_addr_type a;
      void'($urandom(32'hbb52295b));
      $timeformat(-9, 0, " ns", 0);
      for (int i = 0; i < MEM_BYTES; i++) model[i] = '0;  // clear leaves all zero
      rst_n     = 1'b0;
      req_valid = 1'b0;
      req_write = 1'b0;
      req_addr  = '0;
      req_wstrb = '0;
      req_wdata = '0;
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;

      // 1. requests during the clear fail, then every row reads zero
      issue(1'b0, 32'h0, 8'h00, '0);
      issue(1'b1, 32'h8, 8'hff, rand_data());
      idle(3);
      issue(1'b1, 32'h10, 8'h0f, rand_data());
      idle(1);
      n = 0;
      while (ready !== 1'b1 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (ready !== 1'b1) report_failure("ready never rose after the memory clear");
      for (int r = 0; r < ROWS; r++) begin
         issue(1'b0, 32'(r * `SYSBUS_DATA_BYTES) | ($urandom & 32'h7), 8'h00, '0);
      end
      idle(2);

      // 2. full write, strobed merge, read back
      for (int i = 0; i < 48; i++) begin
         a = rand_addr(1'b0);
         issue(1'b1, a, 8'hff, rand_data());
         issue(1'b1, a, types_amba_pkg::sysbus_strb_type'($urandom), rand_data());
         idle(int'($urandom % 3));
         issue(1'b0, a, 8'h00, '0);
      end
      idle(2);

      // 3. back to back on one row, reads must see every earlier write
      for (int j = 0; j < 4; j++) begin
         a = rand_addr(1'b0) & ~32'h7;
         for (int i = 0; i < 24; i++) begin
            issue(($urandom % 2) == 0, a | ($urandom & 32'h7),
                  types_amba_pkg::sysbus_strb_type'($urandom), rand_data());
         end
      end
      idle(2);

      // 4. out of range, aliased low rows stay as they were
      for (int r = 0; r < 8; r++) begin
         a = 32'(r * `SYSBUS_DATA_BYTES);
         issue(1'b1, a | 32'h0000_0400, 8'hff, rand_data());
         issue(1'b0, a | 32'h8000_0000, 8'h00, '0);
         issue(1'b0, a, 8'h00, '0);
      end
      issue(1'b1, 32'hffff_fff8, 8'hff, rand_data());
      issue(1'b0, 32'hffff_fff8, 8'h00, '0);
      idle(2);

      // 5. random mix with random gaps
      for (int i = 0; i < N_RANDOM; i++) begin
         issue(($urandom % 2) == 0, rand_addr(1'b1),
               types_amba_pkg::sysbus_strb_type'($urandom), rand_data());
         n = int'($urandom % 4);
         if (n != 0) idle(n);
      end
      idle(2);

      // drain what is still in flight
      n = 0;
      while (exp_data_q.size() != 0 && n < TIMEOUT) begin
         @(posedge clk);
         n++;
      end
      if (exp_data_q.size() != 0) begin
         $display("%0d responses never arrived", exp_data_q.size());
         $display("ERRORS FOUND");
         $fatal(1, "final drain timed out");
      end else begin
         $display("NO ERRORS");
         $finish;
      end
   end

endmodule

/* types_amba_pkg.sv */
//////////////////////////////
// bus side types shared by the request path, the memory and the testbench
//////////////////////////////

`include "sram_settings.svh"

package types_amba_pkg;

   //////////////////////////////
   // address
   //////////////////////////////

   // one byte address on the system bus
   typedef logic [`SYSBUS_ADDR_BITS-1:0] global_addr_type;

   // entry k addresses 32-bit half k of the bus word
   typedef global_addr_type global_addr_array_type
      [0:`SYSBUS_DATA_BYTES/`SYSBUS_ALIGN_BYTES-1];

   //////////////////////////////
   // data
   //////////////////////////////

   typedef logic [`SYSBUS_DATA_BITS-1:0] sysbus_data_type;

   // one bit per byte lane
   typedef logic [`SYSBUS_DATA_BYTES-1:0] sysbus_strb_type;

endpackage

/* vlog.f */
+incdir+.
types_amba_pkg.sv
sram_pkg.sv
sram8_inferred.sv
srambytes_tech.sv
sram_req_ctrl.sv
sram_resp_ctrl.sv
sram_subsys_top.sv
tb_sram_subsys.sv
